// File: cpu_core.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/forward.sv
hdl/fetch.sv
hdl/regwalls.sv
hdl/cpu_core.sv
dv/cpu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the cpu_core testbench, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing -f cpu_core.f --top-module cpu_core_tb -Mdir obj_dir &&
./obj_dir/Vcpu_core_tb || exit 1

// File: dv/cpu_core_patterns.hex
// @00 header: program words, store records, data words
// @08 data memory words from byte 0, @10 program, @40 stores as addr, data, overflow flag
@00
0000001F
0000000A
00000003
@08
7FFFFFFF
00001234
00000005
@10
44100005 // movi r1, 5
44200003 // movi r2, 3
40308800 // add r3, r1, r2
40418401 // sub r4, r3, r1
40520C03 // xor r5, r4, r3
40628904 // or r6, r5, r2 << 1
40731002 // and r7, r6, r4
44800200 // movi r8, 0x200
14340000 // swi r3, [r8 + 0]
14440001 // swi r4, [r8 + 1]
14540002 // swi r5, [r8 + 2]
14640003 // swi r6, [r8 + 3]
14740004 // swi r7, [r8 + 4]
04900001 // lwi r9, [r0 + 1]
40A48400 // add r10, r9, r1
14A40005 // swi r10, [r8 + 5]
04B00002 // lwi r11, [r0 + 2]
14B40006 // swi r11, [r8 + 6]
50C00005 // addi r12, r0, 5
4CC08004 // beq r12, r1, +8 bytes
1424000F // marker, skipped
4CC0C004 // bne r12, r1, not taken
14C40007 // swi r12, [r8 + 7]
48000004 // j +8 bytes
1424000F // marker, skipped
50000077 // addi r0, r0, 0x77
14040008 // swi r0, [r8 + 8]
04D00000 // lwi r13, [r0 + 0]
50E68001 // addi r14, r13, 1 overflows
14E40009 // swi r14, [r8 + 9]
48000000 // j to itself
@40
00000200 00000008 00000000
00000204 00000003 00000000
00000208 0000000B 00000000
0000020C 0000000F 00000000
00000210 00000003 00000000
00000214 00001239 00000000
00000218 00000005 00000000
0000021C 00000005 00000000
00000220 00000000 00000000
00000224 80000000 00000001

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_core_defines.svh"

module cpu_core_tb;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_LOW_CYCLES = 64;
	localparam int DRAIN_CYCLES = 20;
	localparam int DM_WORDS = 1 << (`CPU_DM_AWIDTH - 2);
	localparam int IM_WORDS = 1 << `CPU_IM_AWIDTH;
	localparam int DATA_BASE = 8;
	localparam int PROG_BASE = 16;
	localparam int STORE_BASE = 64;

	logic clk;
	logic reset;
	logic enable;
	isa_pkg::word_t instr;
	logic im_read;
	logic im_enable;
	isa_pkg::im_addr_t im_addr;
	logic dm_read;
	logic dm_write;
	logic dm_enable;
	isa_pkg::dm_addr_t dm_addr;
	isa_pkg::word_t dm_wdata;
	isa_pkg::word_t dm_rdata;
	logic alu_overflow;

	isa_pkg::word_t pat [128];
	isa_pkg::word_t imem [IM_WORDS];
	isa_pkg::word_t dmem [DM_WORDS];
	int prog_len;
	int store_count;
	int data_count;
	int store_idx;
	int cycle_cnt;
	int gap_left;
	int low_total;
	logic ov_seen;
	logic loaded;
	logic [31:0] lfsr_state;

	cpu_core u_dut (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.instr(instr),
		.im_read(im_read),
		.im_enable(im_enable),
		.im_addr(im_addr),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_enable(dm_enable),
		.dm_addr(dm_addr),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata),
		.alu_overflow(alu_overflow)
	);

	always #(PERIOD / 2) clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_addr(input string name, input isa_pkg::dm_addr_t exp,
		input isa_pkg::dm_addr_t act);
		if (act !== exp)
			report_failure($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_word(input string name, input isa_pkg::word_t exp,
		input isa_pkg::word_t act);
		if (act !== exp)
			report_failure($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
	endtask

	// fibonacci taps 32, 22, 2, 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	task automatic check_store();
		int rec;
		rec = STORE_BASE + 3 * store_idx;
		if (store_idx >= store_count)
			report_failure("a store happened after the last expected one");
		check_addr($sformatf("store %0d address", store_idx),
			pat[rec][`CPU_DM_AWIDTH-1:0], dm_addr);
		check_word($sformatf("store %0d data", store_idx), pat[rec + 1], dm_wdata);
		check_bit($sformatf("store %0d overflow", store_idx), pat[rec + 2][0], ov_seen);
		ov_seen = 1'b0;
		store_idx++;
		dmem[dm_addr[`CPU_DM_AWIDTH-1:2]] = dm_wdata;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		instr = '0;
		dm_rdata = '0;
		lfsr_state = 32'h9312_35f6;
		store_idx = 0;
		cycle_cnt = 0;
		gap_left = 0;
		low_total = 0;
		ov_seen = 1'b0;
		loaded = 1'b0;
		$readmemh("dv/cpu_core_patterns.hex", pat);
		prog_len = int'(pat[0]);
		store_count = int'(pat[1]);
		data_count = int'(pat[2]);
		// words past the program decode to no effect and carry their index
		for (int i = 0; i < IM_WORDS; i++) begin
			imem[i] = (i < prog_len) ? pat[PROG_BASE + i] : (32'h8000_0000 | i);
		end
		// untouched words carry their own index
		for (int i = 0; i < DM_WORDS; i++) begin
			dmem[i] = (i < data_count) ? pat[DATA_BASE + i] : (32'hc0de_0000 | i);
		end
		loaded = 1'b1;
		wait (store_idx == store_count);
		repeat (DRAIN_CYCLES) @(negedge clk);
		check_bit("overflow after last store", 1'b0, ov_seen);
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		int timeout_ns;
		wait (loaded);
		timeout_ns = (40 * prog_len + MAX_LOW_CYCLES + RESET_CYCLES) * PERIOD;
		#(timeout_ns);
		report_failure($sformatf("timeout with %0d of %0d stores seen", store_idx,
			store_count));
	end

	// memories answer and inputs change on the falling edge
	always @(negedge clk) begin
		cycle_cnt++;
		check_bit("im_read", enable, im_read);
		check_bit("im_enable", enable, im_enable);
		check_bit("dm_enable", enable, dm_enable);
		if ((dm_read || dm_write) && !enable)
			report_failure("a data memory strobe was high while enable was low");
		if (reset) begin
			check_bit("alu_overflow in reset", 1'b0, alu_overflow);
		end else begin
			ov_seen = ov_seen | alu_overflow;
			if (dm_write)
				check_store();
		end
		instr = imem[im_addr];
		// read data only moves on a read strobe
		if (dm_read)
			dm_rdata = dmem[dm_addr[`CPU_DM_AWIDTH-1:2]];
		if (cycle_cnt < RESET_CYCLES) begin
			reset = 1'b1;
			enable = 1'b0;
		end else begin
			reset = 1'b0;
			if (gap_left != 0) begin
				enable = 1'b0;
				gap_left--;
				low_total++;
			end else begin
				enable = 1'b1;
				// gaps of 1 to 4 cycles while the total stays in budget
				if (low_total + 4 < MAX_LOW_CYCLES && rand_bits(3) == 0)
					gap_left = rand_bits(2) + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_core_defines.svh"

module cpu_core (
	input  logic              clk,
	input  logic              reset,
	input  logic              enable,
	input  isa_pkg::word_t    instr,
	output logic              im_read,
	output logic              im_enable,
	output isa_pkg::im_addr_t im_addr,
	output logic              dm_read,
	output logic              dm_write,
	output logic              dm_enable,
	output isa_pkg::dm_addr_t dm_addr,
	output isa_pkg::word_t    dm_wdata,
	input  isa_pkg::word_t    dm_rdata,
	output logic              alu_overflow
);

	isa_pkg::pc_t pc;
	isa_pkg::word_t instr_q;
	isa_pkg::instr_r_t id_fields;
	pipe_pkg::ctrl_t ctrl;
	isa_pkg::word_t imm;
	logic use_rt_as_src;
	isa_pkg::reg_addr_t rb_addr;
	isa_pkg::reg_addr_t rt_addr;
	isa_pkg::word_t ra_raw, rb_raw, rt_raw;
	isa_pkg::word_t fwd_ra, fwd_rb, fwd_rt;
	isa_pkg::word_t src2;
	logic stall;
	logic flush;
	pipe_pkg::id_ex_t id_ex_in, id_ex_q;
	pipe_pkg::ex_mem_t ex_mem_in, ex_mem_q;
	pipe_pkg::mem_wb_t mem_wb_in, mem_wb_q;
	isa_pkg::word_t ex_result;
	logic ex_overflow;
	isa_pkg::word_t mem_result;

	assign id_fields = instr_q;

	// operands the instruction does not read go to r0
	assign rb_addr = ctrl.use_imm ? '0 : id_fields.rb;
	assign rt_addr = use_rt_as_src ? id_fields.rt : '0;
	assign src2 = ctrl.use_imm ? imm : (fwd_rb << id_fields.sv);

	assign id_ex_in = '{ctrl: ctrl, ra_data: fwd_ra, src2: src2, rt_data: fwd_rt,
		dest: id_fields.rt, valid: 1'b1};
	assign ex_mem_in = '{ctrl: id_ex_q.ctrl, alu_result: ex_result,
		rt_data: id_ex_q.rt_data, dest: id_ex_q.dest, valid: id_ex_q.valid};
	assign mem_result = (ex_mem_q.ctrl.wb_sel == pipe_pkg::MEM) ? dm_rdata :
		ex_mem_q.alu_result;
	assign mem_wb_in = '{reg_write: ex_mem_q.valid && ex_mem_q.ctrl.reg_write,
		dest: ex_mem_q.dest, data: mem_result};

	assign im_read = enable;
	assign im_enable = enable;
	assign im_addr = pc[`CPU_IM_AWIDTH+1:2];

	assign dm_read = enable && ex_mem_q.valid && ex_mem_q.ctrl.dm_read;
	assign dm_write = enable && ex_mem_q.valid && ex_mem_q.ctrl.dm_write;
	assign dm_enable = enable;
	assign dm_addr = ex_mem_q.alu_result[`CPU_DM_AWIDTH-1:0];
	assign dm_wdata = ex_mem_q.rt_data;

	// address adds of loads and stores do not count
	assign alu_overflow = ex_overflow && id_ex_q.valid &&
		(id_ex_q.ctrl.wb_sel == pipe_pkg::ALU);

	decoder u_decoder (
		.instr(instr_q),
		.ctrl(ctrl),
		.imm(imm),
		.use_rt_as_src(use_rt_as_src)
	);

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.ra_addr(id_fields.ra),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.we(mem_wb_q.reg_write && enable),
		.wr_addr(mem_wb_q.dest),
		.wr_data(mem_wb_q.data),
		.ra_data(ra_raw),
		.rb_data(rb_raw),
		.rt_data(rt_raw)
	);

	forward u_forward (
		.ra_addr(id_fields.ra),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ra_raw(ra_raw),
		.rb_raw(rb_raw),
		.rt_raw(rt_raw),
		.id_ex(id_ex_q),
		.ex_result(ex_result),
		.ex_mem(ex_mem_q),
		.mem_result(mem_result),
		.mem_wb(mem_wb_q),
		.fwd_ra(fwd_ra),
		.fwd_rb(fwd_rb),
		.fwd_rt(fwd_rt),
		.stall(stall)
	);

	fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.stall(stall),
		.opcode(id_fields.opcode),
		.br_sub(instr_q[14]),
		.offset(imm),
		.ra_val(fwd_ra),
		.rt_val(fwd_rt),
		.pc(pc),
		.flush(flush)
	);

	alu u_alu (
		.op(id_ex_q.ctrl.alu_op),
		.a(id_ex_q.ra_data),
		.b(id_ex_q.src2),
		.result(ex_result),
		.overflow(ex_overflow)
	);

	regwalls u_regwalls (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.stall(stall),
		.flush(flush),
		.instr_in(instr),
		.id_ex_in(id_ex_in),
		.ex_mem_in(ex_mem_in),
		.mem_wb_in(mem_wb_in),
		.instr_q(instr_q),
		.id_ex_q(id_ex_q),
		.ex_mem_q(ex_mem_q),
		.mem_wb_q(mem_wb_q)
	);

endmodule

`default_nettype wire

// File: hdl/regwalls.sv
`timescale 1ns/1ns
`default_nettype none

module regwalls (
	input  logic              clk,
	input  logic              reset,
	input  logic              enable,
	input  logic              stall,
	input  logic              flush,
	input  isa_pkg::word_t    instr_in,
	input  pipe_pkg::id_ex_t  id_ex_in,
	input  pipe_pkg::ex_mem_t ex_mem_in,
	input  pipe_pkg::mem_wb_t mem_wb_in,
	output isa_pkg::word_t    instr_q,
	output pipe_pkg::id_ex_t  id_ex_q,
	output pipe_pkg::ex_mem_t ex_mem_q,
	output pipe_pkg::mem_wb_t mem_wb_q
);

	// IF/ID
	always_ff @(posedge clk) begin
		if (reset) begin
			instr_q <= isa_pkg::NOP;
		end else if (enable) begin
			if (flush)
				instr_q <= isa_pkg::NOP;
			else if (!stall)
				instr_q <= instr_in;
		end
	end

	// ID/EX, load-use inserts a bubble here
	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex_q <= '0;
		end else if (enable) begin
			if (stall)
				id_ex_q <= '0;
			else
				id_ex_q <= id_ex_in;
		end
	end

	// EX/MEM
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem_q <= '0;
		end else if (enable) begin
			ex_mem_q <= ex_mem_in;
		end
	end

	// MEM/WB
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb_q <= '0;
		end else if (enable) begin
			mem_wb_q <= mem_wb_in;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch (
	input  logic             clk,
	input  logic             reset,
	input  logic             enable,
	input  logic             stall,
	input  isa_pkg::opcode_e opcode,
	input  logic             br_sub,
	input  isa_pkg::word_t   offset,
	input  isa_pkg::word_t   ra_val,
	input  isa_pkg::word_t   rt_val,
	output isa_pkg::pc_t     pc,
	output logic             flush
);

	isa_pkg::pc_t id_pc;
	isa_pkg::pc_t target;
	logic take;

	// ID holds the word fetched one slot before pc
	assign id_pc = pc - 32'd4;
	assign target = id_pc + (offset << 1);

	always_comb begin
		case (opcode)
			isa_pkg::BR: begin
				// bit 14 selects bne
				if (br_sub)
					take = (rt_val != ra_val);
				else
					take = (rt_val == ra_val);
			end
			isa_pkg::J: take = 1'b1;
			default:    take = 1'b0;
		endcase
	end

	// operands not ready while stalled
	assign flush = take && !stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (enable) begin
			if (flush)
				pc <= target;
			else if (!stall)
				pc <= pc + 32'd4;
		end
	end

endmodule

`default_nettype wire

// File: hdl/forward.sv
`timescale 1ns/1ns
`default_nettype none

module forward (
	input  isa_pkg::reg_addr_t ra_addr,
	input  isa_pkg::reg_addr_t rb_addr,
	input  isa_pkg::reg_addr_t rt_addr,
	input  isa_pkg::word_t     ra_raw,
	input  isa_pkg::word_t     rb_raw,
	input  isa_pkg::word_t     rt_raw,
	input  pipe_pkg::id_ex_t   id_ex,
	input  isa_pkg::word_t     ex_result,
	input  pipe_pkg::ex_mem_t  ex_mem,
	input  isa_pkg::word_t     mem_result,
	input  pipe_pkg::mem_wb_t  mem_wb,
	output isa_pkg::word_t     fwd_ra,
	output isa_pkg::word_t     fwd_rb,
	output isa_pkg::word_t     fwd_rt,
	output logic               stall
);

	logic ex_writes;
	logic ex_load;
	logic mem_writes;

	// a load in EX has no data yet
	assign ex_writes = id_ex.valid && id_ex.ctrl.reg_write &&
		(id_ex.ctrl.wb_sel == pipe_pkg::ALU);
	assign ex_load = id_ex.valid && id_ex.ctrl.dm_read && id_ex.ctrl.reg_write;
	assign mem_writes = ex_mem.valid && ex_mem.ctrl.reg_write;

	function automatic isa_pkg::word_t pick(input isa_pkg::reg_addr_t addr,
		input isa_pkg::word_t raw);
		if (addr == '0)
			return raw;
		if (ex_writes && id_ex.dest == addr)
			return ex_result;
		if (mem_writes && ex_mem.dest == addr)
			return mem_result;
		if (mem_wb.reg_write && mem_wb.dest == addr)
			return mem_wb.data;
		return raw;
	endfunction

	always_comb begin
		fwd_ra = pick(ra_addr, ra_raw);
		fwd_rb = pick(rb_addr, rb_raw);
		fwd_rt = pick(rt_addr, rt_raw);
	end

	// unused operand addresses arrive as r0
	assign stall = ex_load && (id_ex.dest != '0) &&
		(id_ex.dest == ra_addr || id_ex.dest == rb_addr || id_ex.dest == rt_addr);

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  pipe_pkg::alu_op_e op,
	input  isa_pkg::word_t    a,
	input  isa_pkg::word_t    b,
	output isa_pkg::word_t    result,
	output logic              overflow
);

	localparam int MSB = $bits(isa_pkg::word_t) - 1;

	isa_pkg::word_t sum;
	isa_pkg::word_t diff;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		overflow = 1'b0;
		case (op)
			pipe_pkg::ADD: begin
				result = sum;
				// same-sign operands, result sign flipped
				overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			pipe_pkg::SUB: begin
				result = diff;
				overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			pipe_pkg::AND:    result = a & b;
			pipe_pkg::OR:     result = a | b;
			pipe_pkg::XOR:    result = a ^ b;
			pipe_pkg::PASS_B: result = b;
			default:          result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_core_defines.svh"

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  isa_pkg::reg_addr_t ra_addr,
	input  isa_pkg::reg_addr_t rb_addr,
	input  isa_pkg::reg_addr_t rt_addr,
	input  logic               we,
	input  isa_pkg::reg_addr_t wr_addr,
	input  isa_pkg::word_t     wr_data,
	output isa_pkg::word_t     ra_data,
	output isa_pkg::word_t     rb_data,
	output isa_pkg::word_t     rt_data
);

	isa_pkg::word_t regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			// r0 never written, stays zero from reset
			regs[wr_addr] <= wr_data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder (
	input  isa_pkg::word_t  instr,
	output pipe_pkg::ctrl_t ctrl,
	output isa_pkg::word_t  imm,
	output logic            use_rt_as_src
);

	isa_pkg::instr_r_t fields;

	assign fields = instr;

	always_comb begin
		ctrl = '0;
		imm = '0;
		use_rt_as_src = 1'b0;
		case (fields.opcode)
			isa_pkg::ALU_REG: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = pipe_pkg::ALU;
				case (fields.sub_op)
					isa_pkg::ADD: ctrl.alu_op = pipe_pkg::ADD;
					isa_pkg::SUB: ctrl.alu_op = pipe_pkg::SUB;
					isa_pkg::AND: ctrl.alu_op = pipe_pkg::AND;
					isa_pkg::OR:  ctrl.alu_op = pipe_pkg::OR;
					isa_pkg::XOR: ctrl.alu_op = pipe_pkg::XOR;
					default: begin
						// unsupported sub-op retires as a no-op
						ctrl.reg_write = 1'b0;
						ctrl.wb_sel = pipe_pkg::NONE;
					end
				endcase
			end
			isa_pkg::ADDI: begin
				imm = {{17{instr[14]}}, instr[14:0]};
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = pipe_pkg::ADD;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = pipe_pkg::ALU;
			end
			isa_pkg::ORI: begin
				imm = {17'b0, instr[14:0]};
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = pipe_pkg::OR;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = pipe_pkg::ALU;
			end
			isa_pkg::MOVI: begin
				imm = {{12{instr[19]}}, instr[19:0]};
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = pipe_pkg::PASS_B;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = pipe_pkg::ALU;
			end
			isa_pkg::LWI: begin
				// word offset, scaled to bytes
				imm = {{15{instr[14]}}, instr[14:0], 2'b00};
				ctrl.use_imm = 1'b1;
				ctrl.dm_read = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = pipe_pkg::MEM;
			end
			isa_pkg::SWI: begin
				imm = {{15{instr[14]}}, instr[14:0], 2'b00};
				ctrl.use_imm = 1'b1;
				ctrl.dm_write = 1'b1;
				use_rt_as_src = 1'b1;
			end
			isa_pkg::BR: begin
				// halfword offset, scaled in fetch
				imm = {{18{instr[13]}}, instr[13:0]};
				ctrl.use_imm = 1'b1;
				use_rt_as_src = 1'b1;
			end
			isa_pkg::J: begin
				imm = {{8{instr[23]}}, instr[23:0]};
				ctrl.use_imm = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef enum logic [2:0] {
		ADD    = 3'd0,
		SUB    = 3'd1,
		AND    = 3'd2,
		OR     = 3'd3,
		XOR    = 3'd4,
		PASS_B = 3'd5
	} alu_op_e;

	// NONE is zero so a cleared bundle is a bubble
	typedef enum logic [1:0] {
		NONE = 2'd0,
		ALU  = 2'd1,
		MEM  = 2'd2
	} wb_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    dm_read;
		logic    dm_write;
		logic    reg_write;
		wb_sel_e wb_sel;
	} ctrl_t;

	typedef struct packed {
		ctrl_t              ctrl;
		isa_pkg::word_t     ra_data;
		isa_pkg::word_t     src2;
		isa_pkg::word_t     rt_data;
		isa_pkg::reg_addr_t dest;
		logic               valid;
	} id_ex_t;

	typedef struct packed {
		ctrl_t              ctrl;
		isa_pkg::word_t     alu_result;
		isa_pkg::word_t     rt_data;
		isa_pkg::reg_addr_t dest;
		logic               valid;
	} ex_mem_t;

	typedef struct packed {
		logic               reg_write;
		isa_pkg::reg_addr_t dest;
		isa_pkg::word_t     data;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
`default_nettype none

`include "cpu_core_defines.svh"

package isa_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_XLEN-1:0] pc_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;
	typedef logic [`CPU_IM_AWIDTH-1:0] im_addr_t;
	typedef logic [`CPU_DM_AWIDTH-1:0] dm_addr_t;

	typedef enum logic [5:0] {
		ALU_REG = 6'b100000,
		ADDI    = 6'b101000,
		ORI     = 6'b101100,
		MOVI    = 6'b100010,
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		BR      = 6'b100110,
		J       = 6'b100100
	} opcode_e;

	// sub_op_base of the register ALU group
	typedef enum logic [4:0] {
		ADD = 5'b00000,
		SUB = 5'b00001,
		AND = 5'b00010,
		XOR = 5'b00011,
		OR  = 5'b00100
	} alu_sub_e;

	// register-form field layout
	typedef struct packed {
		logic       rsvd;
		opcode_e    opcode;
		reg_addr_t  rt;
		reg_addr_t  ra;
		reg_addr_t  rb;
		logic [1:0] sv;
		logic [2:0] func;
		alu_sub_e   sub_op;
	} instr_r_t;

	// all-zero word decodes to no effect
	localparam word_t NOP = '0;

endpackage

`default_nettype wire

// File: common/cpu_core_defines.svh
`ifndef CPU_CORE_DEFINES_SVH
`define CPU_CORE_DEFINES_SVH

// datapath width
`define CPU_XLEN 32

// architectural registers, r0 reads as zero
`define CPU_REG_COUNT 32

// instruction memory word index
`define CPU_IM_AWIDTH 10

// data memory byte address
`define CPU_DM_AWIDTH 12

`endif
